// File: common/icache_pkg.sv
`default_nettype none

package icache_pkg;

    // Byte address on the fetch side and on the memory side
    localparam int ADDR_WIDTH = 32;

    // Instruction and memory data word
    localparam int WORD_WIDTH = 32;

    // Byte select bits inside one word
    localparam int BYTE_OFFSET_BITS = 2;

    typedef logic [ADDR_WIDTH-1:0] addr_t;

    typedef logic [WORD_WIDTH-1:0] word_t;

    // ST_IDLE accepts requests and answers hits
    // ST_REFILL collects the burst words of a miss
    // ST_FILL_DONE writes the line and returns the word
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REFILL,
        ST_FILL_DONE
    } ctrl_state_e;

endpackage

`default_nettype wire

// File: icache/icache_tags.sv
`timescale 1ns/1ps
`default_nettype none

module icache_tags #(
    parameter int NUM_SETS    = 8,
    parameter int NUM_WAYS    = 4,
    parameter int BLOCK_WORDS = 4
) (
    input  wire                          Clk,
    input  wire                          rst_n,
    input  wire icache_pkg::addr_t       lookup_addr,
    output logic                         hit,
    output logic [$clog2(NUM_WAYS)-1:0]  hit_way,
    output logic [$clog2(NUM_WAYS)-1:0]  victim_way,
    input  wire                          fill_en,
    input  wire icache_pkg::addr_t       fill_addr,
    input  wire [$clog2(NUM_WAYS)-1:0]   fill_way
);

    localparam int WAY_BITS    = $clog2(NUM_WAYS);
    localparam int INDEX_BITS  = $clog2(NUM_SETS);
    localparam int OFFSET_BITS = icache_pkg::BYTE_OFFSET_BITS + $clog2(BLOCK_WORDS);
    localparam int TAG_BITS    = icache_pkg::ADDR_WIDTH - INDEX_BITS - OFFSET_BITS;

    logic [TAG_BITS-1:0] tag_mem [NUM_SETS][NUM_WAYS];
    logic [NUM_WAYS-1:0] valid_q [NUM_SETS];
    logic [WAY_BITS-1:0] rr_ptr_q [NUM_SETS];

    logic [INDEX_BITS-1:0] lk_set;
    logic [TAG_BITS-1:0]   lk_tag;
    logic [INDEX_BITS-1:0] fl_set;
    logic [TAG_BITS-1:0]   fl_tag;
    logic [NUM_WAYS-1:0]   match;

    assign lk_set = lookup_addr[OFFSET_BITS +: INDEX_BITS];
    assign lk_tag = lookup_addr[icache_pkg::ADDR_WIDTH-1 -: TAG_BITS];
    assign fl_set = fill_addr[OFFSET_BITS +: INDEX_BITS];
    assign fl_tag = fill_addr[icache_pkg::ADDR_WIDTH-1 -: TAG_BITS];

    // Compare against every valid way of the set
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            match[w] = valid_q[lk_set][w] && (tag_mem[lk_set][w] == lk_tag);
            if (match[w]) begin
                hit     = 1'b1;
                hit_way = WAY_BITS'(w);
            end
        end
    end

    // Lowest invalid way wins, otherwise the set's pointer
    always_comb begin
        victim_way = rr_ptr_q[lk_set];
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (!valid_q[lk_set][w]) begin
                victim_way = WAY_BITS'(w);
            end
        end
    end

    always_ff @(posedge Clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_q[s]  <= '0;
                rr_ptr_q[s] <= '0;
            end
        end else if (fill_en) begin
            valid_q[fl_set][fill_way] <= 1'b1;
            rr_ptr_q[fl_set]          <= rr_ptr_q[fl_set] + 1'b1;
        end
    end

    always_ff @(posedge Clk) begin
        if (fill_en) begin
            tag_mem[fl_set][fill_way] <= fl_tag;
        end
    end

    // Controller only refills blocks that missed, so a block lives in one way
    a_single_match: assert property (@(posedge Clk) disable iff (!rst_n)
        $onehot0(match));

endmodule

`default_nettype wire

// File: icache/icache_data.sv
`timescale 1ns/1ps
`default_nettype none

module icache_data #(
    parameter int NUM_SETS    = 8,
    parameter int NUM_WAYS    = 4,
    parameter int BLOCK_WORDS = 4
) (
    input  wire                                        Clk,
    input  wire icache_pkg::addr_t                     rd_addr,
    input  wire [$clog2(NUM_WAYS)-1:0]                 rd_way,
    output icache_pkg::word_t                          rd_word,
    input  wire                                        fill_en,
    input  wire icache_pkg::addr_t                     fill_addr,
    input  wire [$clog2(NUM_WAYS)-1:0]                 fill_way,
    input  wire icache_pkg::word_t [BLOCK_WORDS-1:0]   fill_block
);

    localparam int WORD_SEL_BITS = $clog2(BLOCK_WORDS);
    localparam int INDEX_BITS    = $clog2(NUM_SETS);
    localparam int OFFSET_BITS   = icache_pkg::BYTE_OFFSET_BITS + WORD_SEL_BITS;

    icache_pkg::word_t data_mem [NUM_SETS][NUM_WAYS][BLOCK_WORDS];

    logic [INDEX_BITS-1:0]    rd_set;
    logic [WORD_SEL_BITS-1:0] rd_off;
    logic [INDEX_BITS-1:0]    fl_set;

    assign rd_set = rd_addr[OFFSET_BITS +: INDEX_BITS];
    assign rd_off = rd_addr[icache_pkg::BYTE_OFFSET_BITS +: WORD_SEL_BITS];
    assign fl_set = fill_addr[OFFSET_BITS +: INDEX_BITS];

    // Word select by set, way and offset
    assign rd_word = data_mem[rd_set][rd_way][rd_off];

    // Whole block lands in one way
    always_ff @(posedge Clk) begin
        if (fill_en) begin
            for (int b = 0; b < BLOCK_WORDS; b++) begin
                data_mem[fl_set][fill_way][b] <= fill_block[b];
            end
        end
    end

endmodule

`default_nettype wire

// File: icache/icache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl #(
    parameter int NUM_SETS    = 8,
    parameter int NUM_WAYS    = 4,
    parameter int BLOCK_WORDS = 4
) (
    input  wire                                        Clk,
    input  wire                                        rst_n,
    input  wire                                        ReadEnable,
    input  wire icache_pkg::addr_t                     ReadAddress,
    output icache_pkg::word_t                          Instruction,
    output logic                                       Ready,
    output logic                                       Busy,
    output icache_pkg::addr_t                          MemReadAddress,
    output logic                                       MemReadRequest,
    input  wire icache_pkg::word_t                     MemDataIn,
    input  wire                                        MemDataReady,
    output icache_pkg::addr_t                          lookup_addr,
    input  wire                                        hit,
    input  wire [$clog2(NUM_WAYS)-1:0]                 hit_way,
    input  wire [$clog2(NUM_WAYS)-1:0]                 victim_way,
    input  wire icache_pkg::word_t                     rd_word,
    output logic                                       fill_en,
    output icache_pkg::addr_t                          fill_addr,
    output logic [$clog2(NUM_WAYS)-1:0]                fill_way,
    output icache_pkg::word_t [BLOCK_WORDS-1:0]        fill_block
);

    localparam int WAY_BITS      = $clog2(NUM_WAYS);
    localparam int WORD_SEL_BITS = $clog2(BLOCK_WORDS);
    localparam int OFFSET_BITS   = icache_pkg::BYTE_OFFSET_BITS + WORD_SEL_BITS;
    localparam int BLK_BITS      = icache_pkg::ADDR_WIDTH - OFFSET_BITS;
    localparam logic [WORD_SEL_BITS-1:0] LAST_BEAT = WORD_SEL_BITS'(BLOCK_WORDS - 1);

    icache_pkg::ctrl_state_e state_q;

    logic                                 hit_pending_q;
    logic [WORD_SEL_BITS-1:0]             beat_cnt_q;
    icache_pkg::word_t                    hit_word_q;
    icache_pkg::addr_t                    miss_addr_q;
    logic [WAY_BITS-1:0]                  victim_q;
    icache_pkg::word_t [BLOCK_WORDS-1:0]  block_q;
    logic                                 accept;
    logic [WORD_SEL_BITS-1:0]             miss_off;

    assign accept   = (state_q == icache_pkg::ST_IDLE) && ReadEnable;
    assign miss_off = miss_addr_q[icache_pkg::BYTE_OFFSET_BITS +: WORD_SEL_BITS];

    // Fetch address while idle, held miss address during refill
    assign lookup_addr = (state_q == icache_pkg::ST_IDLE) ? ReadAddress : miss_addr_q;

    assign fill_en    = (state_q == icache_pkg::ST_FILL_DONE);
    assign fill_addr  = miss_addr_q;
    assign fill_way   = victim_q;
    assign fill_block = block_q;

    always_ff @(posedge Clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q        <= icache_pkg::ST_IDLE;
            Ready          <= 1'b0;
            Busy           <= 1'b0;
            MemReadRequest <= 1'b0;
            hit_pending_q  <= 1'b0;
            beat_cnt_q     <= '0;
        end else begin
            Ready         <= 1'b0;
            hit_pending_q <= 1'b0;
            case (state_q)
                icache_pkg::ST_IDLE: begin
                    // Hit from the previous edge goes out now
                    Ready <= hit_pending_q;
                    if (ReadEnable) begin
                        if (hit) begin
                            hit_pending_q <= 1'b1;
                        end else begin
                            state_q        <= icache_pkg::ST_REFILL;
                            Busy           <= 1'b1;
                            MemReadRequest <= 1'b1;
                            beat_cnt_q     <= '0;
                        end
                    end
                end
                icache_pkg::ST_REFILL: begin
                    if (MemDataReady) begin
                        beat_cnt_q <= beat_cnt_q + 1'b1;
                        if (beat_cnt_q == LAST_BEAT) begin
                            state_q <= icache_pkg::ST_FILL_DONE;
                        end
                    end
                end
                icache_pkg::ST_FILL_DONE: begin
                    Ready          <= 1'b1;
                    Busy           <= 1'b0;
                    MemReadRequest <= 1'b0;
                    state_q        <= icache_pkg::ST_IDLE;
                end
                default: state_q <= icache_pkg::ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge Clk) begin
        if (accept) begin
            hit_word_q     <= rd_word;
            miss_addr_q    <= ReadAddress;
            victim_q       <= victim_way;
            MemReadAddress <= {ReadAddress[icache_pkg::ADDR_WIDTH-1:OFFSET_BITS],
                               {OFFSET_BITS{1'b0}}};
        end
        if (state_q == icache_pkg::ST_REFILL && MemDataReady) begin
            block_q[beat_cnt_q] <= MemDataIn;
        end
        if (hit_pending_q) begin
            Instruction <= hit_word_q;
        end else if (state_q == icache_pkg::ST_FILL_DONE) begin
            Instruction <= block_q[miss_off];
        end
    end

    a_req_implies_busy: assert property (@(posedge Clk) disable iff (!rst_n)
        MemReadRequest |-> Busy);

    a_no_fetch_while_busy: assert property (@(posedge Clk) disable iff (!rst_n)
        Busy |-> !ReadEnable);

    a_burst_only_in_refill: assert property (@(posedge Clk) disable iff (!rst_n)
        MemDataReady |-> (state_q == icache_pkg::ST_REFILL));

    // A block just written must hit in the way it was written to
    a_fill_then_hit: assert property (@(posedge Clk) disable iff (!rst_n)
        $past(fill_en) && accept &&
        (lookup_addr[icache_pkg::ADDR_WIDTH-1 -: BLK_BITS] ==
         $past(fill_addr[icache_pkg::ADDR_WIDTH-1 -: BLK_BITS]))
        |-> hit && (hit_way == $past(fill_way)));

endmodule

`default_nettype wire

// File: icache/icache_top.sv
`timescale 1ns/1ps
`default_nettype none

module icache_top #(
    parameter int NUM_SETS    = 8,
    parameter int NUM_WAYS    = 4,
    parameter int BLOCK_WORDS = 4
) (
    input  wire                     Clk,
    input  wire                     rst_n,
    // Fetch side
    input  wire                     ReadEnable,
    input  wire icache_pkg::addr_t  ReadAddress,
    output icache_pkg::word_t       Instruction,
    output logic                    Ready,
    output logic                    Busy,
    // SDRAM controller side
    output icache_pkg::addr_t       MemReadAddress,
    output logic                    MemReadRequest,
    input  wire icache_pkg::word_t  MemDataIn,
    input  wire                     MemDataReady
);

    localparam int WAY_BITS = $clog2(NUM_WAYS);

    icache_pkg::addr_t                    lookup_addr;
    logic                                 hit;
    logic [WAY_BITS-1:0]                  hit_way;
    logic [WAY_BITS-1:0]                  victim_way;
    icache_pkg::word_t                    rd_word;
    logic                                 fill_en;
    icache_pkg::addr_t                    fill_addr;
    logic [WAY_BITS-1:0]                  fill_way;
    icache_pkg::word_t [BLOCK_WORDS-1:0]  fill_block;

    icache_ctrl #(
        .NUM_SETS    (NUM_SETS),
        .NUM_WAYS    (NUM_WAYS),
        .BLOCK_WORDS (BLOCK_WORDS)
    ) u_ctrl (
        .Clk            (Clk),
        .rst_n          (rst_n),
        .ReadEnable     (ReadEnable),
        .ReadAddress    (ReadAddress),
        .Instruction    (Instruction),
        .Ready          (Ready),
        .Busy           (Busy),
        .MemReadAddress (MemReadAddress),
        .MemReadRequest (MemReadRequest),
        .MemDataIn      (MemDataIn),
        .MemDataReady   (MemDataReady),
        .lookup_addr    (lookup_addr),
        .hit            (hit),
        .hit_way        (hit_way),
        .victim_way     (victim_way),
        .rd_word        (rd_word),
        .fill_en        (fill_en),
        .fill_addr      (fill_addr),
        .fill_way       (fill_way),
        .fill_block     (fill_block)
    );

    icache_tags #(
        .NUM_SETS    (NUM_SETS),
        .NUM_WAYS    (NUM_WAYS),
        .BLOCK_WORDS (BLOCK_WORDS)
    ) u_tags (
        .Clk         (Clk),
        .rst_n       (rst_n),
        .lookup_addr (lookup_addr),
        .hit         (hit),
        .hit_way     (hit_way),
        .victim_way  (victim_way),
        .fill_en     (fill_en),
        .fill_addr   (fill_addr),
        .fill_way    (fill_way)
    );

    // Data read follows the tag store's hit way
    icache_data #(
        .NUM_SETS    (NUM_SETS),
        .NUM_WAYS    (NUM_WAYS),
        .BLOCK_WORDS (BLOCK_WORDS)
    ) u_data (
        .Clk        (Clk),
        .rd_addr    (lookup_addr),
        .rd_way     (hit_way),
        .rd_word    (rd_word),
        .fill_en    (fill_en),
        .fill_addr  (fill_addr),
        .fill_way   (fill_way),
        .fill_block (fill_block)
    );

endmodule

`default_nettype wire

// File: tb/sdram_model.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_model #(
    parameter int BLOCK_WORDS = 4
) (
    input  wire                     Clk,
    input  wire                     MemReadRequest,
    input  wire icache_pkg::addr_t  MemReadAddress,
    output icache_pkg::word_t       MemDataIn,
    output logic                    MemDataReady,
    output int                      req_count
);

    localparam time DRIVE_DELAY = 10;

    integer            seed;
    icache_pkg::addr_t blk_addr;

    task automatic next_cycle();
        @(posedge Clk);
        #DRIVE_DELAY;
    endtask

    initial begin
        seed         = 32'had59b39d;
        MemDataIn    = '0;
        MemDataReady = 1'b0;
        req_count    = 0;
        forever begin
            next_cycle();
            if (MemReadRequest === 1'b1) begin
                req_count++;
                blk_addr = MemReadAddress;
                for (int i = 0; i < BLOCK_WORDS; i++) begin
                    // Zero to three idle cycles before each word
                    MemDataReady = 1'b0;
                    repeat ($unsigned($random(seed)) % 4) begin
                        next_cycle();
                    end
                    MemDataReady = 1'b1;
                    MemDataIn    = (blk_addr + 4 * i) ^ 32'h5A5A_0000;
                    next_cycle();
                end
                MemDataReady = 1'b0;
                // Request drops at the fill edge
                while (MemReadRequest === 1'b1) begin
                    next_cycle();
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: tb/icache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module icache_tb;

    localparam int  NUM_SETS       = 8;
    localparam int  NUM_WAYS       = 4;
    localparam int  BLOCK_WORDS    = 4;
    localparam int  BLOCK_BYTES    = BLOCK_WORDS * 4;
    localparam int  SET_STRIDE     = BLOCK_BYTES * NUM_SETS;
    localparam time CLK_PERIOD     = 100;
    localparam time DRIVE_DELAY    = 10;
    localparam int  RESET_CYCLES   = 5;
    localparam int  RANDOM_FETCHES = 12;
    // Worst miss is acceptance, four words with three idle cycles each, then the fill
    localparam int  MISS_CYCLES    = 2 + 4 * BLOCK_WORDS;
    localparam int  FETCH_LIMIT    = 2 * MISS_CYCLES;
    localparam int  FETCH_COUNT    = 1 + 4 + 2 * NUM_WAYS + 5 + 2 * RANDOM_FETCHES + 3;
    localparam int  TEST_CYCLES    = RESET_CYCLES + MISS_CYCLES + FETCH_COUNT * MISS_CYCLES;
    localparam int  WATCHDOG_CYCLES = 4 * TEST_CYCLES;
    localparam icache_pkg::addr_t COLD_ADDR  = 32'h0000_1008;
    localparam icache_pkg::addr_t SET_BASE   = 32'h0000_4050;
    localparam icache_pkg::addr_t ABORT_ADDR = 32'h0002_0000;

    logic              Clk = 1'b0;
    logic              rst_n;
    logic              ReadEnable;
    icache_pkg::addr_t ReadAddress;
    icache_pkg::word_t Instruction;
    logic              Ready;
    logic              Busy;
    icache_pkg::addr_t MemReadAddress;
    logic              MemReadRequest;
    icache_pkg::word_t MemDataIn;
    logic              MemDataReady;
    int                req_count;
    integer            seed;
    int                mismatch_count;
    int                failure_count;

    // Expected residency, kept by the replacement rule
    icache_pkg::addr_t model_blk [NUM_SETS][NUM_WAYS];
    logic              model_valid [NUM_SETS][NUM_WAYS];
    int                model_ptr [NUM_SETS];

    icache_top #(
        .NUM_SETS    (NUM_SETS),
        .NUM_WAYS    (NUM_WAYS),
        .BLOCK_WORDS (BLOCK_WORDS)
    ) UUT (
        .Clk            (Clk),
        .rst_n          (rst_n),
        .ReadEnable     (ReadEnable),
        .ReadAddress    (ReadAddress),
        .Instruction    (Instruction),
        .Ready          (Ready),
        .Busy           (Busy),
        .MemReadAddress (MemReadAddress),
        .MemReadRequest (MemReadRequest),
        .MemDataIn      (MemDataIn),
        .MemDataReady   (MemDataReady)
    );

    sdram_model #(
        .BLOCK_WORDS (BLOCK_WORDS)
    ) u_sdram (
        .Clk            (Clk),
        .MemReadRequest (MemReadRequest),
        .MemReadAddress (MemReadAddress),
        .MemDataIn      (MemDataIn),
        .MemDataReady   (MemDataReady),
        .req_count      (req_count)
    );

    always #(CLK_PERIOD / 2) Clk = ~Clk;

    function automatic icache_pkg::word_t mem_word(input icache_pkg::addr_t a);
        return a ^ 32'h5A5A_0000;
    endfunction

    // True on a miss; the expected line is then filled
    function automatic logic predict_miss(input icache_pkg::addr_t a);
        int                idx;
        int                victim;
        icache_pkg::addr_t blk;
        blk    = a - (a % BLOCK_BYTES);
        idx    = (a / BLOCK_BYTES) % NUM_SETS;
        victim = -1;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (model_valid[idx][w] && model_blk[idx][w] == blk) begin
                return 1'b0;
            end
            if (victim < 0 && !model_valid[idx][w]) begin
                victim = w;
            end
        end
        if (victim < 0) begin
            victim = model_ptr[idx];
        end
        model_valid[idx][victim] = 1'b1;
        model_blk[idx][victim]   = blk;
        model_ptr[idx]           = (model_ptr[idx] + 1) % NUM_WAYS;
        return 1'b1;
    endfunction

    task automatic compare(input string what, input logic [31:0] actual,
                           input logic [31:0] expected);
        if (actual !== expected) begin
            mismatch_count++;
            $display("MISMATCH at %0t ns: %s: got %h, expected %h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic apply_reset(input int cycles);
        rst_n = 1'b0;
        repeat (cycles) begin
            @(posedge Clk);
        end
        #DRIVE_DELAY;
        compare("Ready in reset", Ready, 1'b0);
        compare("Busy in reset", Busy, 1'b0);
        compare("MemReadRequest in reset", MemReadRequest, 1'b0);
        rst_n = 1'b1;
        for (int s = 0; s < NUM_SETS; s++) begin
            model_ptr[s] = 0;
            for (int w = 0; w < NUM_WAYS; w++) begin
                model_valid[s][w] = 1'b0;
            end
        end
    endtask

    task automatic fetch_and_check(input icache_pkg::addr_t addr);
        logic miss;
        logic busy_before;
        int   req_before;
        int   cycles;
        miss        = predict_miss(addr);
        req_before  = req_count;
        busy_before = 1'b0;
        cycles      = 0;
        ReadEnable  = 1'b1;
        ReadAddress = addr;
        @(posedge Clk);
        #DRIVE_DELAY;
        ReadEnable = 1'b0;
        while (!Ready && cycles < FETCH_LIMIT) begin
            busy_before = Busy;
            @(posedge Clk);
            #DRIVE_DELAY;
            cycles++;
        end
        if (!Ready) begin
            failure_count++;
            $display("No Ready within %0d cycles of the fetch of %h", FETCH_LIMIT, addr);
        end else begin
            compare("fetched word", Instruction, mem_word(addr));
            compare("memory requests", req_count - req_before, miss);
            compare("Busy with Ready", Busy, 1'b0);
            compare("MemReadRequest with Ready", MemReadRequest, 1'b0);
            if (miss) begin
                compare("memory address", MemReadAddress, addr - (addr % BLOCK_BYTES));
                compare("Busy before Ready", busy_before, 1'b1);
            end else begin
                compare("hit latency", cycles, 1);
            end
        end
    endtask

    task automatic cold_miss();
        int req_before;
        req_before = req_count;
        fetch_and_check(COLD_ADDR);
        compare("requests for cold miss", req_count - req_before, 1);
    endtask

    // Ready trails each of the one-per-cycle acceptances by one cycle
    task automatic back_to_back_hits();
        icache_pkg::addr_t addrs [3];
        int                req_before;
        addrs      = '{32'h0000_1000, 32'h0000_1004, 32'h0000_100C};
        req_before = req_count;
        for (int i = 0; i < 3; i++) begin
            ReadEnable  = 1'b1;
            ReadAddress = addrs[i];
            @(posedge Clk);
            #DRIVE_DELAY;
            if (i == 0) begin
                compare("Ready before first hit", Ready, 1'b0);
            end else begin
                compare("Ready after hit", Ready, 1'b1);
                compare("hit word", Instruction, mem_word(addrs[i - 1]));
            end
        end
        ReadEnable = 1'b0;
        @(posedge Clk);
        #DRIVE_DELAY;
        compare("Ready after last hit", Ready, 1'b1);
        compare("last hit word", Instruction, mem_word(addrs[2]));
        @(posedge Clk);
        #DRIVE_DELAY;
        compare("Ready width", Ready, 1'b0);
        compare("requests for hits", req_count - req_before, 0);
    endtask

    task automatic fill_one_set();
        int req_before;
        for (int k = 0; k < NUM_WAYS; k++) begin
            fetch_and_check(SET_BASE + k * SET_STRIDE);
        end
        req_before = req_count;
        for (int k = 0; k < NUM_WAYS; k++) begin
            fetch_and_check(SET_BASE + k * SET_STRIDE + 4);
        end
        compare("requests for resident set", req_count - req_before, 0);
    endtask

    // Fifth block takes way 0, so only the first block is gone
    task automatic replace_in_set();
        int req_before;
        fetch_and_check(SET_BASE + NUM_WAYS * SET_STRIDE);
        req_before = req_count;
        for (int k = 1; k < NUM_WAYS; k++) begin
            fetch_and_check(SET_BASE + k * SET_STRIDE + 8);
        end
        compare("requests for surviving blocks", req_count - req_before, 0);
        fetch_and_check(SET_BASE + 8);
        compare("requests for evicted block", req_count - req_before, 1);
    endtask

    task automatic random_latency_misses();
        icache_pkg::addr_t addr;
        for (int i = 0; i < RANDOM_FETCHES; i++) begin
            addr = $random(seed) & 32'h0000_FFFC;
            fetch_and_check(addr);
            fetch_and_check(addr ^ 32'h0000_0004);
        end
    endtask

    // Reset lands in the middle of a refill
    task automatic mid_run_reset();
        int req_before;
        fetch_and_check(COLD_ADDR);
        ReadEnable  = 1'b1;
        ReadAddress = ABORT_ADDR;
        @(posedge Clk);
        #DRIVE_DELAY;
        ReadEnable = 1'b0;
        @(posedge Clk);
        #DRIVE_DELAY;
        compare("Busy during refill", Busy, 1'b1);
        compare("MemReadRequest during refill", MemReadRequest, 1'b1);
        // Long enough for the memory to finish the cut burst
        apply_reset(MISS_CYCLES);
        req_before = req_count;
        fetch_and_check(COLD_ADDR);
        compare("requests after reset", req_count - req_before, 1);
    endtask

    initial begin
        seed           = 32'had59b39d;
        rst_n          = 1'b0;
        ReadEnable     = 1'b0;
        ReadAddress    = '0;
        mismatch_count = 0;
        failure_count  = 0;
        apply_reset(RESET_CYCLES);
        cold_miss();
        back_to_back_hits();
        fill_one_set();
        replace_in_set();
        random_latency_misses();
        mid_run_reset();
        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
        if (mismatch_count + failure_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
common/icache_pkg.sv
icache/icache_tags.sv
icache/icache_data.sv
icache/icache_ctrl.sv
icache/icache_top.sv
tb/sdram_model.sv
tb/icache_tb.sv
